/* source/isaPkg.sv */
// Instruction-set types and encodings shared by the decode and datapath modules
package isaPkg;

	typedef logic [15:0] wordT;   // Data word
	typedef logic [15:0] instrT;  // Raw instruction
	typedef logic [2:0]  regIdxT; // Register number
	typedef logic [4:0]  opCodeT; // Instr[15:11]
	typedef logic [1:0]  functT;  // Instr[1:0] in R format

	localparam int numRegs = 8;

	localparam opCodeT opHalt  = 5'b00000;
	localparam opCodeT opNop   = 5'b00001;
	localparam opCodeT opAddi  = 5'b01000;
	localparam opCodeT opSubi  = 5'b01001;
	localparam opCodeT opXori  = 5'b01010;
	localparam opCodeT opAndni = 5'b01011;
	localparam opCodeT opRoli  = 5'b10100;
	localparam opCodeT opSlli  = 5'b10101;
	localparam opCodeT opRori  = 5'b10110;
	localparam opCodeT opSrli  = 5'b10111;
	localparam opCodeT opSt    = 5'b10000;
	localparam opCodeT opLd    = 5'b10001;
	localparam opCodeT opStu   = 5'b10011;
	localparam opCodeT opBtr   = 5'b11001;
	localparam opCodeT opArith = 5'b11011; // ADD SUB XOR ANDN
	localparam opCodeT opShift = 5'b11010; // ROL SLL ROR SRL
	localparam opCodeT opSeq   = 5'b11100;
	localparam opCodeT opSlt   = 5'b11101;
	localparam opCodeT opSle   = 5'b11110;
	localparam opCodeT opSco   = 5'b11111;
	localparam opCodeT opLbi   = 5'b11000;
	localparam opCodeT opSlbi  = 5'b10010;

	localparam functT fnAdd  = 2'b00; // Under opArith
	localparam functT fnSub  = 2'b01;
	localparam functT fnXor  = 2'b10;
	localparam functT fnAndn = 2'b11;
	localparam functT fnRol  = 2'b00; // Under opShift
	localparam functT fnSll  = 2'b01;
	localparam functT fnRor  = 2'b10;
	localparam functT fnSrl  = 2'b11;

endpackage

/* source/ctrlPkg.sv */
// Control-signal encodings passed from the decoder down the pipeline, plus memory sizing
package ctrlPkg;

	typedef logic [2:0] aluOpT;   // ALU function select
	typedef logic [1:0] cmpOpT;   // Compare-and-set condition
	typedef logic [1:0] regDstT;  // Destination field select
	typedef logic [1:0] specOpT;  // Special result path

	localparam aluOpT aluRol = 3'b000;
	localparam aluOpT aluSll = 3'b001;
	localparam aluOpT aluRor = 3'b010; // Old sra slot
	localparam aluOpT aluSrl = 3'b011;
	localparam aluOpT aluAdd = 3'b100;
	localparam aluOpT aluAnd = 3'b101;
	localparam aluOpT aluOr  = 3'b110;
	localparam aluOpT aluXor = 3'b111;

	localparam cmpOpT cmpEq    = 2'b00;
	localparam cmpOpT cmpLt    = 2'b01;
	localparam cmpOpT cmpLe    = 2'b10;
	localparam cmpOpT cmpCarry = 2'b11;

	localparam regDstT dstRs = 2'b00; // Instr[10:8]
	localparam regDstT dstRt = 2'b01; // Instr[7:5]
	localparam regDstT dstRd = 2'b10; // Instr[4:2]

	localparam specOpT specNone = 2'b00;
	localparam specOpT specBtr  = 2'b01;
	localparam specOpT specLbi  = 2'b10;
	localparam specOpT specSlbi = 2'b11;

	localparam int dataMemDepth = 256;                 // Words
	localparam int memAddrW     = $clog2(dataMemDepth); // Taken from address bits above bit 0

endpackage

/* source/controlDecode.sv */
// Combinational control unit; decodeStage feeds it opcode and function code each cycle
`timescale 1ns/1ps

module controlDecode (
	input  isaPkg::opCodeT  opCode,
	input  isaPkg::functT   funct,
	output logic            err,
	output logic            halt,
	output ctrlPkg::regDstT regDst,
	output logic            imm5,      // 5-bit immediate, else 8-bit
	output logic            signImm,
	output ctrlPkg::aluOpT  aluOp,
	output logic            aluSrc,    // Immediate as source B
	output logic            cIn,
	output logic            invA,
	output logic            invB,
	output logic            memWrite,
	output logic            memRead,
	output logic            cmpSet,
	output ctrlPkg::cmpOpT  cmpOp,
	output logic            memToReg,
	output logic            regWrite,
	output ctrlPkg::specOpT specialOp
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		err = 1'b0;
		halt = 1'b0;
		regDst = dstRs;
		imm5 = 1'b0;
		signImm = 1'b0;
		aluOp = aluRol;
		aluSrc = 1'b0;
		cIn = 1'b0;
		invA = 1'b0;
		invB = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		cmpSet = 1'b0;
		cmpOp = cmpEq;
		memToReg = 1'b0;
		regWrite = 1'b0;
		specialOp = specNone;

		// I format 1 shares dest, immediate size and source B
		if (opCode inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
				opSt, opLd, opStu}) begin
			regDst = dstRt;
			imm5 = 1'b1;
			aluSrc = 1'b1;
		end
		// R format writes Rd
		if (opCode inside {opBtr, opArith, opShift, opSeq, opSlt, opSle, opSco})
			regDst = dstRd;

		case (opCode)
			opHalt: halt = 1'b1;
			opNop: ;                          // Nothing to do
			opAddi: begin
				signImm = 1'b1;
				aluOp = aluAdd;
				regWrite = 1'b1;
			end
			opSubi: begin                     // I - Rs
				signImm = 1'b1;
				aluOp = aluAdd;
				invA = 1'b1;
				cIn = 1'b1;
				regWrite = 1'b1;
			end
			opXori: begin
				aluOp = aluXor;
				regWrite = 1'b1;
			end
			opAndni: begin
				aluOp = aluAnd;
				invB = 1'b1;
				regWrite = 1'b1;
			end
			opRoli: regWrite = 1'b1;          // aluRol is the default
			opSlli: begin
				aluOp = aluSll;
				regWrite = 1'b1;
			end
			opRori: begin
				aluOp = aluRor;
				regWrite = 1'b1;
			end
			opSrli: begin
				aluOp = aluSrl;
				regWrite = 1'b1;
			end
			opSt: begin                       // Address is Rs + I
				signImm = 1'b1;
				aluOp = aluAdd;
				memWrite = 1'b1;
			end
			opLd: begin
				signImm = 1'b1;
				aluOp = aluAdd;
				memRead = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			opStu: begin                      // Store, then base gets the address
				regDst = dstRs;
				signImm = 1'b1;
				aluOp = aluAdd;
				memWrite = 1'b1;
				regWrite = 1'b1;
			end
			opBtr: begin
				specialOp = specBtr;
				regWrite = 1'b1;
			end
			opArith: begin
				regWrite = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: begin              // Rt - Rs
						aluOp = aluAdd;
						invA = 1'b1;
						cIn = 1'b1;
					end
					fnXor: aluOp = aluXor;
					fnAndn: begin
						aluOp = aluAnd;
						invB = 1'b1;
					end
				endcase
			end
			opShift: begin
				regWrite = 1'b1;
				case (funct)
					fnRol: aluOp = aluRol;
					fnSll: aluOp = aluSll;
					fnRor: aluOp = aluRor;
					fnSrl: aluOp = aluSrl;
				endcase
			end
			opSeq, opSlt, opSle: begin        // Rs - Rt then test
				aluOp = aluAdd;
				invB = 1'b1;
				cIn = 1'b1;
				cmpSet = 1'b1;
				cmpOp = (opCode == opSeq) ? cmpEq : (opCode == opSlt) ? cmpLt : cmpLe;
				regWrite = 1'b1;
			end
			opSco: begin                      // Carry out of Rs + Rt
				aluOp = aluAdd;
				cmpSet = 1'b1;
				cmpOp = cmpCarry;
				regWrite = 1'b1;
			end
			opLbi: begin
				signImm = 1'b1;
				specialOp = specLbi;
				regWrite = 1'b1;
			end
			opSlbi: begin                     // Zero-extended low byte
				specialOp = specSlbi;
				regWrite = 1'b1;
			end
			default: err = 1'b1;              // Control flow, siic, RTI, unassigned
		endcase
	end

endmodule

/* source/decodeStage.sv */
// First pipeline stage; registers each accepted instruction with its decoded controls
`timescale 1ns/1ps

module decodeStage (
	input  logic             clk,
	input  logic             rstN,
	input  logic             instrValid,
	input  isaPkg::instrT    instr,
	output logic             decValid,
	output logic             decErr,
	output logic             decHalt,
	output ctrlPkg::aluOpT   decAluOp,
	output logic             decAluSrc,
	output logic             decCIn,
	output logic             decInvA,
	output logic             decInvB,
	output logic             decMemWrite,
	output logic             decMemRead,
	output logic             decCmpSet,
	output ctrlPkg::cmpOpT   decCmpOp,
	output logic             decMemToReg,
	output logic             decRegWrite,
	output ctrlPkg::specOpT  decSpecOp,
	output isaPkg::regIdxT   rsIdx,
	output isaPkg::regIdxT   rtIdx,
	output isaPkg::regIdxT   destIdx,
	output isaPkg::wordT     imm
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic    err, halt, imm5, signImm, aluSrc, cIn, invA, invB;
	logic    memWrite, memRead, cmpSet, memToReg, regWrite;
	regDstT  regDst;
	aluOpT   aluOp;
	cmpOpT   cmpOp;
	specOpT  specialOp;
	regIdxT  dest;
	wordT    immExt;
	logic    seenHalt;                       // Sticky, blocks issue after HALT
	logic    accept;

	controlDecode ctrl0 (
		.opCode(instr[15:11]), .funct(instr[1:0]),
		.err, .halt, .regDst, .imm5, .signImm, .aluOp, .aluSrc, .cIn, .invA, .invB,
		.memWrite, .memRead, .cmpSet, .cmpOp, .memToReg, .regWrite, .specialOp
	);

	assign accept = instrValid & ~seenHalt;

	always_comb begin
		case (regDst)
			dstRt:   dest = instr[7:5];
			dstRd:   dest = instr[4:2];
			default: dest = instr[10:8];          // dstRs
		endcase
		if (imm5)
			immExt = signImm ? {{11{instr[4]}}, instr[4:0]} : {11'b0, instr[4:0]};
		else
			immExt = signImm ? {{8{instr[7]}}, instr[7:0]} : {8'b0, instr[7:0]};
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decValid <= 1'b0;
			seenHalt <= 1'b0;
		end else begin
			decValid <= accept;
			if (accept && halt)
				seenHalt <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin              // Payload only, no reset
		if (accept) begin
			decErr <= err;
			decHalt <= halt;
			decAluOp <= aluOp;
			decAluSrc <= aluSrc;
			decCIn <= cIn;
			decInvA <= invA;
			decInvB <= invB;
			decMemWrite <= memWrite;
			decMemRead <= memRead;
			decCmpSet <= cmpSet;
			decCmpOp <= cmpOp;
			decMemToReg <= memToReg;
			decRegWrite <= regWrite;
			decSpecOp <= specialOp;
			rsIdx <= instr[10:8];
			rtIdx <= instr[7:5];
			destIdx <= dest;
			imm <= immExt;
		end
	end

endmodule

/* source/regFile.sv */
// Eight-entry register file; the retire port writes it and also bypasses to both reads
`timescale 1ns/1ps

module regFile (
	input  logic           clk,
	input  logic           rstN,
	input  isaPkg::regIdxT rdIdxA,
	input  isaPkg::regIdxT rdIdxB,
	input  logic           wrEn,
	input  isaPkg::regIdxT wrIdx,
	input  isaPkg::wordT   wrData,
	output isaPkg::wordT   rdDataA,
	output isaPkg::wordT   rdDataB
);
	import isaPkg::*;

	wordT regs [numRegs];

	always_ff @(posedge clk) begin
		if (!rstN)
			regs <= '{default: '0};            // All registers read zero after reset
		else if (wrEn)
			regs[wrIdx] <= wrData;
	end

	// Same-cycle write wins over stored value
	assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
	assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

/* source/executeStage.sv */
// Second stage; latches the decoded op, reads operands and produces the ALU or special result
`timescale 1ns/1ps

module executeStage (
	input  logic            clk,
	input  logic            rstN,
	input  logic            decValid,
	input  logic            decErr,
	input  logic            decHalt,
	input  ctrlPkg::aluOpT  decAluOp,
	input  logic            decAluSrc,
	input  logic            decCIn,
	input  logic            decInvA,
	input  logic            decInvB,
	input  logic            decMemWrite,
	input  logic            decMemRead,
	input  logic            decCmpSet,
	input  ctrlPkg::cmpOpT  decCmpOp,
	input  logic            decMemToReg,
	input  logic            decRegWrite,
	input  ctrlPkg::specOpT decSpecOp,
	input  isaPkg::regIdxT  rsIdx,
	input  isaPkg::regIdxT  rtIdx,
	input  isaPkg::regIdxT  destIdx,
	input  isaPkg::wordT    imm,
	input  isaPkg::wordT    rdDataA,          // Rs from regFile, bypass included
	input  isaPkg::wordT    rdDataB,          // Rt
	output logic            exValid,
	output isaPkg::wordT    exResult,
	output isaPkg::wordT    exStoreData,
	output logic            exMemRead,
	output logic            exMemWrite,
	output logic            exRegWrite,
	output logic            exMemToReg,
	output isaPkg::regIdxT  exDest,
	output logic            exErr,
	output logic            exHalt,
	output isaPkg::regIdxT  rdIdxA,
	output isaPkg::regIdxT  rdIdxB
);
	import isaPkg::*;
	import ctrlPkg::*;

	aluOpT  aluOp;
	cmpOpT  cmpOp;
	specOpT specOp;
	logic   aluSrc, cIn, invA, invB, cmpSet;
	wordT   immQ;
	wordT   opA, opB, sum, aluOut, btr, special;
	logic   cOut, ovf, isEq, isLt, cmpBit;
	logic   [31:0] rolWide, rorWide;        // Doubled word for rotates

	always_ff @(posedge clk) begin
		if (!rstN)
			exValid <= 1'b0;
		else
			exValid <= decValid;
	end

	always_ff @(posedge clk) begin          // Execute register payload
		{exErr, exHalt, exMemRead, exMemWrite} <= {decErr, decHalt, decMemRead, decMemWrite};
		{exRegWrite, exMemToReg, exDest} <= {decRegWrite, decMemToReg, destIdx};
		{aluOp, aluSrc, cIn, invA, invB} <= {decAluOp, decAluSrc, decCIn, decInvA, decInvB};
		{cmpSet, cmpOp, specOp} <= {decCmpSet, decCmpOp, decSpecOp};
		{rdIdxA, rdIdxB, immQ} <= {rsIdx, rtIdx, imm};
	end

	assign opA = invA ? ~rdDataA : rdDataA;
	assign opB = invB ? ~(aluSrc ? immQ : rdDataB) : (aluSrc ? immQ : rdDataB);
	assign {cOut, sum} = opA + opB + cIn;   // 17-bit sum keeps carry
	assign rolWide = {opA, opA} << opB[3:0];
	assign rorWide = {opA, opA} >> opB[3:0];

	always_comb begin
		case (aluOp)
			aluRol:  aluOut = rolWide[31:16];
			aluSll:  aluOut = opA << opB[3:0];
			aluRor:  aluOut = rorWide[15:0];
			aluSrl:  aluOut = opA >> opB[3:0];
			aluAdd:  aluOut = sum;
			aluAnd:  aluOut = opA & opB;
			aluOr:   aluOut = opA | opB;
			default: aluOut = opA ^ opB;    // aluXor
		endcase
	end

	// Compares run on Rs + ~Rt + 1
	assign ovf = (opA[15] == opB[15]) && (sum[15] != opA[15]);
	assign isEq = (sum == '0);
	assign isLt = sum[15] ^ ovf;            // Sign corrected for overflow

	always_comb begin
		case (cmpOp)
			cmpEq:   cmpBit = isEq;
			cmpLt:   cmpBit = isLt;
			cmpLe:   cmpBit = isLt | isEq;
			default: cmpBit = cOut;         // SCO
		endcase
	end

	always_comb begin
		for (int i = 0; i < 16; i++)
			btr[i] = rdDataA[15 - i];
		case (specOp)
			specBtr:  special = btr;
			specLbi:  special = immQ;
			default:  special = (rdDataA << 8) | immQ; // SLBI
		endcase
	end

	assign exResult = (specOp != specNone) ? special :
		cmpSet ? {15'b0, cmpBit} : aluOut;
	assign exStoreData = rdDataB;           // ST source sits in the Rt field

endmodule

/* source/memWbStage.sv */
// Third stage; holds the data memory, retires the register write and tracks halt
`timescale 1ns/1ps

module memWbStage (
	input  logic           clk,
	input  logic           rstN,
	input  logic           exValid,
	input  isaPkg::wordT   exResult,
	input  isaPkg::wordT   exStoreData,
	input  logic           exMemRead,
	input  logic           exMemWrite,
	input  logic           exRegWrite,
	input  logic           exMemToReg,
	input  isaPkg::regIdxT exDest,
	input  logic           exErr,
	input  logic           exHalt,
	output logic           wbValid,
	output isaPkg::regIdxT wbReg,
	output isaPkg::wordT   wbData,
	output logic           retireErr,
	output logic           halted
);
	import isaPkg::*;
	import ctrlPkg::*;

	wordT   dataMem [dataMemDepth];
	logic   mwValid, mwMemRead, mwMemWrite, mwRegWrite, mwMemToReg, mwErr, mwHalt;
	wordT   mwResult, mwStoreData, memRdData;
	logic   haltedQ;
	logic   [memAddrW-1:0] memAddr;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			mwValid <= 1'b0;
			haltedQ <= 1'b0;
		end else begin
			mwValid <= exValid;
			if (mwValid && mwHalt)
				haltedQ <= 1'b1;              // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin          // Payload
		{mwResult, mwStoreData, wbReg} <= {exResult, exStoreData, exDest};
		{mwMemRead, mwMemWrite, mwRegWrite} <= {exMemRead, exMemWrite, exRegWrite};
		{mwMemToReg, mwErr, mwHalt} <= {exMemToReg, exErr, exHalt};
	end

	assign memAddr = mwResult[memAddrW:1];  // Word addressed

	always_ff @(posedge clk) begin
		if (mwValid && mwMemWrite)
			dataMem[memAddr] <= mwStoreData;
	end

	assign memRdData = mwMemRead ? dataMem[memAddr] : '0;
	assign wbData = mwMemToReg ? memRdData : mwResult;
	assign wbValid = mwValid & mwRegWrite;
	assign retireErr = mwValid & mwErr;
	assign halted = haltedQ | (mwValid & mwHalt); // Up in the HALT retire cycle

endmodule

/* source/wiscCore.sv */
// Top level of the three-stage datapath; instructions stream in, register writes stream out
`timescale 1ns/1ps

module wiscCore (
	input  logic           clk,
	input  logic           rstN,
	input  logic           instrValid,
	input  isaPkg::instrT  instr,
	output logic           wbValid,
	output isaPkg::regIdxT wbReg,
	output isaPkg::wordT   wbData,
	output logic           retireErr,
	output logic           halted
);
	import isaPkg::*;
	import ctrlPkg::*;

	// Decode to execute
	logic    decValid, decErr, decHalt, decAluSrc, decCIn, decInvA, decInvB;
	logic    decMemWrite, decMemRead, decCmpSet, decMemToReg, decRegWrite;
	aluOpT   decAluOp;
	cmpOpT   decCmpOp;
	specOpT  decSpecOp;
	regIdxT  rsIdx, rtIdx, destIdx;
	wordT    imm;
	// Execute to memory/writeback
	logic    exValid, exMemRead, exMemWrite, exRegWrite, exMemToReg, exErr, exHalt;
	wordT    exResult, exStoreData;
	regIdxT  exDest;
	// Register file read ports
	regIdxT  rdIdxA, rdIdxB;
	wordT    rdDataA, rdDataB;

	decodeStage dec0 (
		.clk, .rstN, .instrValid, .instr,
		.decValid, .decErr, .decHalt, .decAluOp, .decAluSrc, .decCIn, .decInvA, .decInvB,
		.decMemWrite, .decMemRead, .decCmpSet, .decCmpOp, .decMemToReg, .decRegWrite,
		.decSpecOp, .rsIdx, .rtIdx, .destIdx, .imm
	);

	executeStage ex0 (
		.clk, .rstN,
		.decValid, .decErr, .decHalt, .decAluOp, .decAluSrc, .decCIn, .decInvA, .decInvB,
		.decMemWrite, .decMemRead, .decCmpSet, .decCmpOp, .decMemToReg, .decRegWrite,
		.decSpecOp, .rsIdx, .rtIdx, .destIdx, .imm, .rdDataA, .rdDataB,
		.exValid, .exResult, .exStoreData, .exMemRead, .exMemWrite, .exRegWrite,
		.exMemToReg, .exDest, .exErr, .exHalt, .rdIdxA, .rdIdxB
	);

	regFile rf0 (                           // Retire port doubles as bypass
		.clk, .rstN, .rdIdxA, .rdIdxB,
		.wrEn(wbValid), .wrIdx(wbReg), .wrData(wbData),
		.rdDataA, .rdDataB
	);

	memWbStage mw0 (
		.clk, .rstN, .exValid, .exResult, .exStoreData, .exMemRead, .exMemWrite,
		.exRegWrite, .exMemToReg, .exDest, .exErr, .exHalt,
		.wbValid, .wbReg, .wbData, .retireErr, .halted
	);

endmodule

/* verif/wiscCore_props.sv */
// Retire latency and halt assertions, bound into every wiscCore instance
`timescale 1ns/1ps

module wiscCoreProps (
	input logic clk,
	input logic rstN,
	input logic issueWrite, // Accepted instruction with a register write
	input logic wbValid,
	input logic halted
);

	property retireLatency;
		@(posedge clk) disable iff (!rstN)
		issueWrite |-> ##3 wbValid;        // Sampled edge N, visible after N+2
	endproperty

	property haltSticky;
		@(posedge clk) disable iff (!rstN)
		halted |=> halted;
	endproperty

	property quietWhenHalted;
		@(posedge clk) disable iff (!rstN)
		halted |-> !wbValid;
	endproperty

	assert property (retireLatency) else $error("Register write did not retire 3 cycles after issue");
	assert property (haltSticky) else $error("halted dropped before reset");
	assert property (quietWhenHalted) else $error("wbValid seen while halted");

endmodule

bind wiscCore wiscCoreProps props0 (
	.clk, .rstN,
	.issueWrite(dec0.accept && dec0.regWrite),
	.wbValid, .halted
);

/* verif/wiscCoreTb.sv */
// Table-driven testbench for wiscCore; a model predicts each row and a monitor checks retires
`timescale 1ns/1ps

module wiscCoreTb;
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int kindNone = 0;
	localparam int kindReg  = 1;
	localparam int kindErr  = 2;

	logic   clk, rstN, instrValid;
	instrT  instr;
	logic   wbValid, retireErr, halted;
	regIdxT wbReg;
	wordT   wbData;

	instrT  instrTab[$];             // Stimulus column
	bit     gapTab[$];               // Idle cycles allowed after the row
	int     expKind[$];              // Expected columns, filled by predict
	regIdxT expReg[$];
	wordT   expData[$];
	int     pendQ[$];                // Rows still to retire, oldest first
	wordT   model [numRegs];
	wordT   modelMem [dataMemDepth];
	bit     modelHalted;
	int     errors, tests, gap, waitCount;

	wiscCore dut0 (
		.clk, .rstN, .instrValid, .instr,
		.wbValid, .wbReg, .wbData, .retireErr, .halted
	);

	function automatic instrT iOne(opCodeT op, regIdxT rs, regIdxT rd, logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instrT rType(opCodeT op, regIdxT rs, regIdxT rt, regIdxT rd, functT fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic instrT iTwo(opCodeT op, regIdxT rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic wordT rotl(wordT w, logic [3:0] n);
		return (w << n) | (w >> (5'd16 - n)); // n of 0 gives w
	endfunction

	function automatic wordT rotr(wordT w, logic [3:0] n);
		return (w >> n) | (w << (5'd16 - n));
	endfunction

	function automatic wordT reverseBits(wordT w);
		wordT res;
		for (int i = 0; i < 16; i++)
			res[i] = w[15 - i];
		return res;
	endfunction

	task automatic addRow(input instrT ins, input bit gapOk);
		instrTab.push_back(ins);
		gapTab.push_back(gapOk);
		expKind.push_back(kindNone);
		expReg.push_back('0);
		expData.push_back('0);
	endtask

	// ISA-level model, run in program order over the table
	task automatic predict(input int r);
		instrT       ins;
		wordT        a, b, ea, v, i5s, i5z, i8s, i8z;
		regIdxT      dst;
		logic [16:0] wide;
		ins = instrTab[r];
		a = model[ins[10:8]];                    // Rs
		b = model[ins[7:5]];                     // Rt
		i5s = {{11{ins[4]}}, ins[4:0]};
		i5z = {11'b0, ins[4:0]};
		i8s = {{8{ins[7]}}, ins[7:0]};
		i8z = {8'b0, ins[7:0]};
		ea = a + i5s;                            // LD ST STU address
		wide = {1'b0, a} + {1'b0, b};
		dst = ins[4:2];                          // Rd unless changed below
		v = '0;
		expKind[r] = modelHalted ? kindNone : kindReg;
		if (!modelHalted) begin
			if (ins[15:11] inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
					opSrli, opLd})
				dst = ins[7:5];
			case (ins[15:11])
				opHalt: begin
					expKind[r] = kindNone;
					modelHalted = 1'b1;
				end
				opNop: expKind[r] = kindNone;
				opAddi: v = a + i5s;
				opSubi: v = i5s - a;
				opXori: v = a ^ i5z;
				opAndni: v = a & ~i5z;
				opRoli: v = rotl(a, ins[3:0]);
				opSlli: v = a << ins[3:0];
				opRori: v = rotr(a, ins[3:0]);
				opSrli: v = a >> ins[3:0];
				opSt: begin
					modelMem[ea[8:1]] = b;
					expKind[r] = kindNone;
				end
				opLd: v = modelMem[ea[8:1]];
				opStu: begin
					modelMem[ea[8:1]] = b;
					dst = ins[10:8];
					v = ea;
				end
				opBtr: v = reverseBits(a);
				opArith: v = (ins[1:0] == fnAdd) ? a + b : (ins[1:0] == fnSub) ? b - a :
					(ins[1:0] == fnXor) ? a ^ b : a & ~b;
				opShift: v = (ins[1:0] == fnRol) ? rotl(a, b[3:0]) :
					(ins[1:0] == fnSll) ? a << b[3:0] :
					(ins[1:0] == fnRor) ? rotr(a, b[3:0]) : a >> b[3:0];
				opSeq: v = {15'b0, a == b};
				opSlt: v = {15'b0, $signed(a) < $signed(b)};
				opSle: v = {15'b0, $signed(a) <= $signed(b)};
				opSco: v = {15'b0, wide[16]};
				opLbi: begin
					dst = ins[10:8];
					v = i8s;
				end
				opSlbi: begin
					dst = ins[10:8];
					v = (a << 8) | i8z;
				end
				default: expKind[r] = kindErr;   // Control flow and unassigned
			endcase
		end
		if (expKind[r] == kindReg) begin
			model[dst] = v;
			expReg[r] = dst;
			expData[r] = v;
		end
	endtask

	task automatic buildTable();
		// Constants, then every ALU and shift form
		addRow(iTwo(opLbi, 1, 8'h12), 1);
		addRow(iTwo(opSlbi, 1, 8'h34), 1);
		addRow(iTwo(opLbi, 2, 8'hFD), 1);
		addRow(iTwo(opLbi, 3, 8'h85), 1);
		addRow(iTwo(opSlbi, 3, 8'h0F), 1);
		addRow(iOne(opAddi, 1, 4, 5'h05), 1);
		addRow(iOne(opSubi, 1, 5, 5'h03), 1);
		addRow(iOne(opXori, 3, 4, 5'h1F), 1);
		addRow(iOne(opAndni, 1, 5, 5'h0F), 1);
		addRow(iOne(opRoli, 3, 6, 5'h04), 1);
		addRow(iOne(opSlli, 1, 6, 5'h03), 1);
		addRow(iOne(opRori, 3, 7, 5'h05), 1);
		addRow(iOne(opSrli, 3, 7, 5'h09), 1);
		addRow(rType(opArith, 1, 2, 4, fnAdd), 1);
		addRow(rType(opArith, 1, 3, 5, fnSub), 1);
		addRow(rType(opArith, 1, 3, 6, fnXor), 1);
		addRow(rType(opArith, 1, 3, 7, fnAndn), 1);
		addRow(rType(opShift, 3, 1, 4, fnRol), 1);
		addRow(rType(opShift, 1, 2, 5, fnSll), 1);
		addRow(rType(opShift, 3, 2, 6, fnRor), 1);
		addRow(rType(opShift, 3, 1, 7, fnSrl), 1);
		// Dependent chain, no idle cycles
		addRow(iOne(opAddi, 1, 1, 5'h01), 0);
		addRow(iOne(opAddi, 1, 1, 5'h1F), 0);
		addRow(rType(opArith, 1, 1, 2, fnAdd), 0);
		addRow(rType(opArith, 2, 1, 3, fnSub), 0);
		addRow(iOne(opRori, 3, 3, 5'h01), 0);
		addRow(rType(opArith, 3, 2, 4, fnXor), 1);
		// Compares around the signed limits
		addRow(iTwo(opLbi, 4, 8'h80), 1);
		addRow(iTwo(opSlbi, 4, 8'h00), 1);       // 0x8000
		addRow(iTwo(opLbi, 5, 8'h7F), 1);
		addRow(iTwo(opSlbi, 5, 8'hFF), 1);       // 0x7FFF
		addRow(rType(opSeq, 4, 4, 6, 2'b00), 1);
		addRow(rType(opSeq, 4, 5, 6, 2'b00), 1);
		addRow(rType(opSlt, 4, 5, 6, 2'b00), 1); // Difference overflows
		addRow(rType(opSlt, 5, 4, 6, 2'b00), 1);
		addRow(rType(opSle, 4, 4, 6, 2'b00), 1);
		addRow(rType(opSle, 5, 4, 6, 2'b00), 1);
		addRow(rType(opSco, 4, 4, 6, 2'b00), 1);
		addRow(rType(opSco, 5, 5, 6, 2'b00), 1);
		addRow(rType(opSlt, 2, 2, 7, 2'b00), 1);
		// Memory
		addRow(iTwo(opLbi, 1, 8'h20), 1);
		addRow(iTwo(opLbi, 2, 8'h5A), 1);
		addRow(iOne(opSt, 1, 2, 5'h02), 0);
		addRow(iOne(opLd, 1, 3, 5'h02), 1);
		addRow(iOne(opStu, 1, 2, 5'h04), 0);
		addRow(iOne(opLd, 1, 4, 5'h00), 1);
		addRow(iTwo(opLbi, 5, 8'hFF), 1);
		addRow(iOne(opSt, 1, 5, 5'h1E), 0);      // Overwrites 0x22
		addRow(iOne(opLd, 1, 6, 5'h1E), 1);
		// BTR and illegal opcodes
		addRow(rType(opBtr, 1, 0, 6, 2'b00), 1);
		addRow({5'b00100, 11'h155}, 1);          // J
		addRow({5'b01100, 11'h0A3}, 1);          // BEQZ
		addRow(iOne(opNop, 0, 0, 5'h00), 1);
		// Halt, then nothing retires
		addRow(iOne(opHalt, 0, 0, 5'h00), 0);
		addRow(iOne(opAddi, 1, 1, 5'h01), 0);
		addRow(iTwo(opLbi, 2, 8'h01), 1);
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkReg(input string name, input regIdxT got, input regIdxT exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got r%0d expected r%0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin : retireMonitor  // Mid-cycle, outputs settled
		int r;
		int errBefore;
		if (rstN && (wbValid || retireErr)) begin
			if (pendQ.size() == 0) begin
				$display("Unexpected retire at %0t: no instruction was due to retire", $time);
				errors++;
			end else begin
				r = pendQ.pop_front();
				errBefore = errors;
				checkBit("retireErr", retireErr, expKind[r] == kindErr);
				checkBit("wbValid", wbValid, expKind[r] == kindReg);
				if (expKind[r] == kindReg) begin
					checkReg("wbReg", wbReg, expReg[r]);
					checkWord("wbData", wbData, expData[r]);
				end
				tests++;
				$display("Test %0d row %0d instr %h: %s", tests, r, instrTab[r],
					(errors == errBefore) ? "ok" : "failed");
			end
		end
	end

	initial begin
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		errors = 0;
		tests = 0;
		modelHalted = 1'b0;
		void'($urandom(32'h3fb524ab));
		foreach (model[i])
			model[i] = '0;
		buildTable();
		for (int r = 0; r < instrTab.size(); r++)
			predict(r);
		repeat (4) @(posedge clk);
		#2 rstN = 1'b1;
		checkBit("wbValid", wbValid, 1'b0);       // State right after reset
		checkBit("retireErr", retireErr, 1'b0);
		checkBit("halted", halted, 1'b0);
		for (int r = 0; r < instrTab.size(); r++) begin
			@(posedge clk);
			#2;
			instrValid = 1'b1;
			instr = instrTab[r];
			if (expKind[r] != kindNone)
				pendQ.push_back(r);
			if (gapTab[r]) begin
				gap = $urandom % 3;
				repeat (gap) begin
					@(posedge clk);
					#2;
					instrValid = 1'b0;
					instr = '0;
				end
			end
		end
		@(posedge clk);
		#2;
		instrValid = 1'b0;
		waitCount = 0;
		while (pendQ.size() != 0 && waitCount < 50) begin
			@(negedge clk);
			waitCount++;
		end
		if (pendQ.size() != 0) begin
			$display("Timeout: %0d expected retires never arrived", pendQ.size());
			errors++;
		end
		waitCount = 0;
		while (!halted && waitCount < 20) begin
			@(negedge clk);
			waitCount++;
		end
		if (!halted) begin
			$display("Timeout: halted never rose after HALT");
			errors++;
		end
		repeat (4) @(negedge clk);               // Window for stray retires after HALT
		checkBit("halted", halted, 1'b1);
		$display("Summary: %0d tests checked, %0d errors", tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* list.f */
source/isaPkg.sv
source/ctrlPkg.sv
source/controlDecode.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memWbStage.sv
source/wiscCore.sv
verif/wiscCore_props.sv
verif/wiscCoreTb.sv

/* Bender.yml */
package:
  name: wisc_core

sources:
  - files:
      - source/isaPkg.sv
      - source/ctrlPkg.sv
      - source/controlDecode.sv
      - source/decodeStage.sv
      - source/regFile.sv
      - source/executeStage.sv
      - source/memWbStage.sv
      - source/wiscCore.sv
  - target: simulation
    files:
      - verif/wiscCore_props.sv
      - verif/wiscCoreTb.sv
